/* Bender.yml */
package:
  name: array_drive

export_include_dirs:
  - design

sources:
  - target: any(rtl, simulation)
    include_dirs:
      - design
    files:
      - design/array_drive_pkg.sv
      - design/pwm_timebase.sv
      - design/transducer_channel.sv
      - design/array_drive_top.sv

  - target: simulation
    include_dirs:
      - design
    files:
      - sim/array_drive_tb.sv

/* design/array_drive_pkg.sv */
`include "array_drive_settings.svh"

package array_drive_pkg;

   //////////////////////////////
   // Types
   //////////////////////////////

   typedef logic [`ARRAY_DRIVE_COUNT_W-1:0] count_t;   // Position in carrier period
   typedef logic [`ARRAY_DRIVE_DUTY_W-1:0]  duty_t;    // High time in clocks
   typedef logic [`ARRAY_DRIVE_CHANNELS-1:0] trans_t;  // Bit 0 is channel 1

   typedef count_t phase_table_t [`ARRAY_DRIVE_CHANNELS];
   typedef duty_t  duty_table_t  [`ARRAY_DRIVE_CHANNELS];

   //////////////////////////////
   // Phase points per channel
   //////////////////////////////

   // Count value at which each transducer fires, entry 0 is channel 1
   parameter phase_table_t PHASE_TABLE = '{
      11'd253,   // Shared with ch 24
      11'd1008,
      11'd336,   // Shared with ch 37
      11'd673,
      11'd153,
      11'd48,
      11'd994,
      11'd800,
      11'd236,
      11'd926,   // Ch 10
      11'd126,
      11'd857,
      11'd743,
      11'd301,
      11'd1142,
      11'd730,
      11'd143,
      11'd531,
      11'd49,
      11'd1107,  // Ch 20
      11'd735,
      11'd1248,  // Window wraps past period end
      11'd866,
      11'd253,
      11'd686,
      11'd195,
      11'd0,     // Fires at period start
      11'd829,
      11'd1134,
      11'd714,   // Ch 30
      11'd136,
      11'd482,
      11'd74,
      11'd1107,
      11'd722,
      11'd738,
      11'd336,
      11'd967,
      11'd130,
      11'd878,   // Ch 40
      11'd751,
      11'd329,
      11'd73,
      11'd1037,
      11'd349,
      11'd740,
      11'd223,
      11'd97,
      11'd982    // Ch 49
   };

   //////////////////////////////
   // High length per channel
   //////////////////////////////

   // Output stays high this many clocks after the phase match
   parameter duty_table_t DUTY_TABLE = '{
      10'd264,
      10'd264,
      10'd264,
      10'd319,
      10'd362,
      10'd319,
      10'd197,
      10'd237,
      10'd463,
      10'd319,   // Ch 10
      10'd205,
      10'd264,
      10'd220,
      10'd319,
      10'd220,
      10'd205,
      10'd170,
      10'd220,
      10'd220,
      10'd319,   // Ch 20
      10'd237,
      10'd237,
      10'd185,
      10'd220,
      10'd197,
      10'd220,
      10'd319,
      10'd319,
      10'd237,
      10'd237,   // Ch 30
      10'd185,
      10'd319,
      10'd170,
      10'd319,
      10'd264,
      10'd362,
      10'd264,
      10'd237,
      10'd197,
      10'd220,   // Ch 40
      10'd205,
      10'd264,
      10'd624,   // Close to half the period
      10'd205,
      10'd237,
      10'd185,
      10'd220,
      10'd220,
      10'd220    // Ch 49
   };

endpackage

/* design/array_drive_settings.svh */
`ifndef ARRAY_DRIVE_SETTINGS_SVH
`define ARRAY_DRIVE_SETTINGS_SVH

//////////////////////////////
// Clocking
//////////////////////////////

// System clock feeding the timebase
`define ARRAY_DRIVE_CLK_HZ      50000000

// Ultrasonic carrier
`define ARRAY_DRIVE_CARRIER_HZ  40000

// Clock cycles in one carrier period, 1250 at the rates above
`define ARRAY_DRIVE_PERIOD      (`ARRAY_DRIVE_CLK_HZ / `ARRAY_DRIVE_CARRIER_HZ)

//////////////////////////////
// Array geometry
//////////////////////////////

`define ARRAY_DRIVE_CHANNELS    49  // Transducers on one board

//////////////////////////////
// Counter widths
//////////////////////////////

`define ARRAY_DRIVE_COUNT_W     11  // Holds 0 to PERIOD-1
`define ARRAY_DRIVE_DUTY_W      10  // Longest high time in the tables

`endif

/* design/array_drive_top.sv */
`timescale 1ns/1ps

`include "array_drive_settings.svh"

module array_drive_top (
   input  logic                    CLK,
   input  logic                    arst_n,
   input  logic                    sync,   // Realign strobe from twin board
   output array_drive_pkg::trans_t trans
);

   array_drive_pkg::count_t count;  // Shared carrier position

   //////////////////////////////
   // Shared timebase
   //////////////////////////////

   pwm_timebase i_timebase (
      .CLK    (CLK),
      .arst_n (arst_n),
      .sync   (sync),
      .count  (count)
   );

   //////////////////////////////
   // Transducer channels
   //////////////////////////////

   // Channel i+1 takes table entry i and drives trans[i]
   for (genvar i = 0; i < `ARRAY_DRIVE_CHANNELS; i++) begin : g_channel
      transducer_channel #(
         .PHASE (array_drive_pkg::PHASE_TABLE[i]),
         .DUTY  (array_drive_pkg::DUTY_TABLE[i])
      ) i_channel (
         .CLK    (CLK),
         .arst_n (arst_n),
         .count  (count),
         .trans  (trans[i])
      );
   end

endmodule

/* design/pwm_timebase.sv */
`timescale 1ns/1ps

`include "array_drive_settings.svh"

module pwm_timebase (
   input  logic                    CLK,
   input  logic                    arst_n,
   input  logic                    sync,
   output array_drive_pkg::count_t count
);

   localparam array_drive_pkg::count_t LAST =
      array_drive_pkg::count_t'(`ARRAY_DRIVE_PERIOD - 1);

   logic wrap;

   //////////////////////////////
   // Period counter
   //////////////////////////////

   assign wrap = (count == LAST);  // Final clock of the carrier period

   // Sync from the twin board realigns both arrays to count 0
   always_ff @(posedge CLK or negedge arst_n) begin
      if (!arst_n) begin
         count <= '0;
      end else if (sync || wrap) begin
         count <= '0;                // Restart period
      end else begin
         count <= count + 1'b1;
      end
   end

   //////////////////////////////
   // Checks
   //////////////////////////////

   // Every channel compare relies on count staying inside the period
   a_count_range : assert property (
      @(posedge CLK) disable iff (!arst_n)
      count <= LAST
   ) else $error("count %0d beyond period end", count);

endmodule

/* design/transducer_channel.sv */
`timescale 1ns/1ps

`include "array_drive_settings.svh"

module transducer_channel #(
   parameter array_drive_pkg::count_t PHASE = '0,
   parameter array_drive_pkg::duty_t  DUTY  = 1
) (
   input  logic                    CLK,
   input  logic                    arst_n,
   input  array_drive_pkg::count_t count,
   output logic                    trans
);

   logic                   match;
   logic                   last;
   array_drive_pkg::duty_t duty_cnt;

   //////////////////////////////
   // Parameter range
   //////////////////////////////

   if (PHASE >= `ARRAY_DRIVE_PERIOD) begin : g_bad_phase
      $error("PHASE %0d never reached by the timebase", PHASE);
   end

   if (DUTY == 0) begin : g_bad_duty
      $error("DUTY must be at least one clock");
   end

   //////////////////////////////
   // Phase compare
   //////////////////////////////

   assign match = (count == PHASE);
   assign last  = (duty_cnt == DUTY - 1'b1);  // Final high clock of window

   //////////////////////////////
   // Duty window
   //////////////////////////////

   // The flop on trans is the pin driver, so the window opens one clock
   // after the match and closes DUTY clocks later
   always_ff @(posedge CLK or negedge arst_n) begin
      if (!arst_n) begin
         trans    <= 1'b0;
         duty_cnt <= '0;
      end else if (match) begin
         trans    <= 1'b1;              // Open or restart window
         duty_cnt <= '0;
      end else if (trans) begin
         if (last) begin
            trans    <= 1'b0;           // Window done
            duty_cnt <= '0;
         end else begin
            duty_cnt <= duty_cnt + 1'b1;
         end
      end
   end

   //////////////////////////////
   // Checks
   //////////////////////////////

   // Counter closes the window before it can pass the duty length
   a_duty_bound : assert property (
      @(posedge CLK) disable iff (!arst_n)
      trans |-> (duty_cnt < DUTY)
   ) else $error("duty counter %0d reached DUTY %0d", duty_cnt, DUTY);

   // Output only rises from a phase match
   a_idle_low : assert property (
      @(posedge CLK) disable iff (!arst_n)
      (!trans && !match) |=> !trans
   ) else $error("trans rose without phase match");

endmodule

/* filelist.f */
+incdir+design
design/array_drive_pkg.sv
design/pwm_timebase.sv
design/transducer_channel.sv
design/array_drive_top.sv
sim/array_drive_tb.sv

/* sim/array_drive_tb.sv */
`timescale 1ns/1ps

`include "array_drive_settings.svh"

module array_drive_tb;

   localparam int PERIOD     = `ARRAY_DRIVE_PERIOD;
   localparam int CHANNELS   = `ARRAY_DRIVE_CHANNELS;
   localparam int AGE_MAX    = 4 * PERIOD;      // Model age saturates here
   localparam int WAIT_LIMIT = 3 * PERIOD;      // Longest legal wait in clocks
   localparam int SYNC_COUNT = 16;              // Random strobes in the sync test
   localparam int MID_PERIOD = 600;             // Count at which reset hits

   logic                    CLK;
   logic                    arst_n;
   logic                    sync;
   array_drive_pkg::trans_t trans;

   int                      model_count;        // Expected timebase position
   int                      model_age [CHANNELS];  // Clocks since last match
   int                      rises [CHANNELS];
   logic [31:0]             lfsr_state;
   array_drive_pkg::trans_t trans_prev;

   array_drive_top i_dut (
      .CLK    (CLK),
      .arst_n (arst_n),
      .sync   (sync),
      .trans  (trans)
   );

   initial begin
      CLK = 1'b0;
      forever #5 CLK = ~CLK;                    // 100 MHz sim clock
   end

   //////////////////////////////
   // Reference model
   //////////////////////////////

   // High from one clock after the match for DUTY clocks
   function automatic logic expected_out(int ch, int age);
      return (age >= 1) && (age <= int'(array_drive_pkg::DUTY_TABLE[ch]));
   endfunction

   function automatic array_drive_pkg::trans_t expected_vector();
      array_drive_pkg::trans_t v;
      for (int ch = 0; ch < CHANNELS; ch++) begin
         v[ch] = expected_out(ch, model_age[ch]);
      end
      return v;
   endfunction

   function automatic logic [31:0] lfsr_next(logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 32'h8020_0003;       // Taps 32 22 2 1
      end
      return s >> 1;
   endfunction

   task automatic take_bits(input int n, output int value);
      value = 0;
      for (int i = 0; i < n; i++) begin
         value      = (value << 1) | int'(lfsr_state[0]);
         lfsr_state = lfsr_next(lfsr_state);
      end
   endtask

   task automatic reset_model();
      model_count = 0;
      trans_prev  = '0;
      for (int ch = 0; ch < CHANNELS; ch++) begin
         model_age[ch] = -1;                    // No match seen yet
      end
   endtask

   // Steps the model past the clock that just ended
   task automatic advance_model();
      for (int ch = 0; ch < CHANNELS; ch++) begin
         if (trans[ch] && !trans_prev[ch]) begin
            rises[ch]++;
         end
         if (model_count == int'(array_drive_pkg::PHASE_TABLE[ch])) begin
            model_age[ch] = 1;
         end else if (model_age[ch] >= 1 && model_age[ch] < AGE_MAX) begin
            model_age[ch]++;
         end
      end
      trans_prev = trans;
      if (sync || model_count == PERIOD - 1) begin
         model_count = 0;
      end else begin
         model_count++;
      end
   endtask

   //////////////////////////////
   // Checks
   //////////////////////////////

   task automatic fail_run(string what);
      $display("%s", what);
      $display("=== FAIL ===");
      $fatal(1, "Stopped at first error");
   endtask

   task automatic check_trans(string name, array_drive_pkg::trans_t expected,
                              array_drive_pkg::trans_t actual);
      if (actual !== expected) begin
         fail_run($sformatf("FAIL %s expected %h actual %h at %0t",
                            name, expected, actual, $time));
      end
   endtask

   task automatic check_bit(string name, logic expected, logic actual);
      if (actual !== expected) begin
         fail_run($sformatf("FAIL %s expected %h actual %h at %0t",
                            name, expected, actual, $time));
      end
   endtask

   // Every output bit against the model at each rising edge
   always @(posedge CLK or negedge arst_n) begin
      if (!arst_n) begin
         reset_model();
      end else begin
         check_trans("trans", expected_vector(), trans);
         advance_model();
      end
   end

   initial begin
      #2_000_000;
      fail_run("simulation time limit reached before the test finished");
   end

   //////////////////////////////
   // Stimulus helpers
   //////////////////////////////

   task automatic wait_for_count(int target);
      int cycles;
      cycles = 0;
      while (model_count != target) begin
         @(negedge CLK);
         cycles++;
         if (cycles > WAIT_LIMIT) begin
            fail_run($sformatf("timed out waiting for count %0d", target));
         end
      end
   endtask

   task automatic wait_for_rise(int ch);
      int cycles;
      cycles = 0;
      while (trans[ch] !== 1'b1) begin
         @(negedge CLK);
         cycles++;
         if (cycles > WAIT_LIMIT) begin
            fail_run($sformatf("timed out waiting for channel %0d to rise", ch + 1));
         end
      end
   endtask

   task automatic pulse_sync(int len);
      sync = 1'b1;
      repeat (len) @(negedge CLK);
      sync = 1'b0;
   endtask

   // Called on the falling edge where arst_n is released
   task automatic check_startup();
      array_drive_pkg::trans_t first;
      for (int ch = 0; ch < CHANNELS; ch++) begin
         first[ch] = (array_drive_pkg::PHASE_TABLE[ch] == '0);
      end
      check_trans("trans", '0, trans);
      @(negedge CLK);
      check_trans("trans", first, trans);       // Phase 0 fires in second cycle
      check_bit("trans[26]", 1'b1, trans[26]);
   endtask

   task automatic check_all_rose(int min_rises);
      for (int ch = 0; ch < CHANNELS; ch++) begin
         if (rises[ch] < min_rises) begin
            fail_run($sformatf("channel %0d rose %0d times, expected at least %0d",
                               ch + 1, rises[ch], min_rises));
         end
      end
   endtask

   task automatic check_shared_phase(int a, int b);
      int dmax;
      dmax = int'(array_drive_pkg::DUTY_TABLE[a]);
      if (int'(array_drive_pkg::DUTY_TABLE[b]) > dmax) begin
         dmax = int'(array_drive_pkg::DUTY_TABLE[b]);
      end
      wait_for_count(int'(array_drive_pkg::PHASE_TABLE[a]));
      check_bit($sformatf("trans[%0d]", a), expected_out(a, model_age[a]), trans[a]);
      check_bit($sformatf("trans[%0d]", b), expected_out(b, model_age[b]), trans[b]);
      for (int k = 1; k <= dmax + 1; k++) begin
         @(negedge CLK);
         check_bit($sformatf("trans[%0d]", a), expected_out(a, k), trans[a]);
         check_bit($sformatf("trans[%0d]", b), expected_out(b, k), trans[b]);
      end
   endtask

   task automatic random_syncs(int n);
      int gap;
      for (int i = 0; i < n; i++) begin
         take_bits(11, gap);
         repeat (gap + 1) @(negedge CLK);
         pulse_sync(1);
      end
   endtask

   //////////////////////////////
   // Test sequence
   //////////////////////////////

   initial begin
      arst_n     = 1'b0;
      sync       = 1'b0;
      lfsr_state = 32'd98558;
      for (int ch = 0; ch < CHANNELS; ch++) begin
         rises[ch] = 0;
      end
      reset_model();
      repeat (2) @(negedge CLK);
      arst_n = 1'b1;
      check_startup();

      repeat (3 * PERIOD + 10) @(negedge CLK);  // Three free-running periods
      check_all_rose(3);

      check_shared_phase(0, 23);                // Phase 253
      check_shared_phase(2, 36);                // Phase 336

      // Strobe in channel 1 high time restarts its window
      wait_for_rise(0);
      pulse_sync(1);
      repeat (PERIOD) @(negedge CLK);
      random_syncs(SYNC_COUNT);
      pulse_sync(3);                            // Long strobe parks count at 0
      repeat (2 * PERIOD) @(negedge CLK);

      wait_for_count(MID_PERIOD);
      arst_n = 1'b0;
      #1;
      check_trans("trans", '0, trans);          // Outputs drop at once
      repeat (2) @(negedge CLK);
      arst_n = 1'b1;
      check_startup();
      repeat (PERIOD + 10) @(negedge CLK);

      $display("=== PASS ===");
      $finish;
   end

endmodule
